// File: project.f
design/dcache_pkg.sv
design/dcache_data_ram.sv
design/dcache_tag_ram.sv
design/dcache_ram_arbiter.sv
design/dcache_lookup.sv
design/dcache_rd_path.sv
design/dcache_refill.sv
design/dcache_top.sv
verification/tb_clock.sv
verification/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_data_ram.sv
  - design/dcache_tag_ram.sv
  - design/dcache_ram_arbiter.sv
  - design/dcache_lookup.sv
  - design/dcache_rd_path.sv
  - design/dcache_refill.sv
  - design/dcache_top.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/dcache_tb.sv

// File: verification/dcache_tb.sv
module dcache_tb;
    import dcache_pkg::*;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    req_addr_t         req_addr;
    rd_type_t          req_type;
    logic              req_wr, req_uncache, req_signed, req_atom, req_sc, llbit;
    cacop_t            req_cacop;
    logic [31:0]       req_wdata;
    logic              resp_valid, busy, line_out_valid;
    logic [31:0]       resp_data;
    logic [LINE_W-1:0] line_out, mem_rd_line;
    logic              mem_rd_req, mem_rd_uncache, mem_rd_valid;
    logic [31:0]       mem_rd_addr;

    // what the next request must produce, set before it is issued
    logic              exp_data_en, exp_line_en, exp_fast, rd_ok, exp_rd_unc;
    logic [31:0]       exp_data, exp_rd_addr;
    logic [LINE_W-1:0] exp_line;
    int                rd_count, line_count, cycles;
    int                mem_delay [64];
    logic [31:0]       fetch_addr;
    int                fetch_wait;

    // resident lines per set, replaced round-robin
    logic [TAG_W-1:0]  mdl_tag   [SETS][WAYS];
    logic              mdl_valid [SETS][WAYS];
    int                mdl_ptr   [SETS];

    tb_clock u_clock (.clk(clk));

    dcache_top uut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h2545f491) ^ {a[15:0], a[31:16]} ^ 32'h5a5a1c3d;
    endfunction

    function automatic logic [LINE_W-1:0] mem_line(input logic [31:0] addr);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < 16; w++) begin
            line[w*32 +: 32] = mem_word({addr[31:6], 6'b0} + 32'(w * 4));
        end
        return line;
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] word, input rd_type_t typ,
                                                input logic sgn, input logic [1:0] ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * ofs));
        h = 16'(word >> (8 * ofs));
        if (typ == RT_BYTE) return {{24{sgn && b[7]}}, b};
        if (typ == RT_HALF) return ofs[0] ? 32'h0 : {{16{sgn && h[15]}}, h};
        return word;
    endfunction

    a_reset: assert property (@(posedge clk) (!arst_n && cycles > 0) |->
                              !(busy || resp_valid || line_out_valid || mem_rd_req))
        else abort_run("outputs were not idle during reset");
    a_busy_set: assert property (@(posedge clk) disable iff (!arst_n)
                                 $past(req_valid) |-> busy)
        else abort_run("busy was low while a request was in progress");
    a_busy_clr: assert property (@(posedge clk) disable iff (!arst_n)
                                 $past(resp_valid) |-> !busy)
        else abort_run("busy stayed high after the response");
    a_data: assert property (@(posedge clk) disable iff (!arst_n)
                             (resp_valid && exp_data_en) |-> resp_data == exp_data)
        else abort_run($sformatf("CHECK FAILED t=%0t resp_data exp=%h got=%h",
                                 $time, $sampled(exp_data), $sampled(resp_data)));
    a_line_pulse: assert property (@(posedge clk) disable iff (!arst_n)
                                   line_out_valid |-> exp_line_en)
        else abort_run("line_out_valid pulsed when no line was due");
    a_line: assert property (@(posedge clk) disable iff (!arst_n)
                             line_out_valid |-> line_out == exp_line)
        else abort_run($sformatf("CHECK FAILED t=%0t line_out exp=%h got=%h",
                                 $time, $sampled(exp_line), $sampled(line_out)));
    a_rd_ok: assert property (@(posedge clk) disable iff (!arst_n) mem_rd_req |-> rd_ok)
        else abort_run("memory read issued where the access needs none");
    a_rd_unc: assert property (@(posedge clk) disable iff (!arst_n)
                               mem_rd_req |-> mem_rd_uncache == exp_rd_unc)
        else abort_run($sformatf("CHECK FAILED t=%0t mem_rd_uncache exp=%b got=%b",
                                 $time, $sampled(exp_rd_unc), $sampled(mem_rd_uncache)));
    // an uncached fetch names its word and a cached one only its line
    a_rd_addr: assert property (@(posedge clk) disable iff (!arst_n)
                                mem_rd_req |-> (exp_rd_unc ?
                                                mem_rd_addr[31:2] == exp_rd_addr[31:2] :
                                                mem_rd_addr[31:6] == exp_rd_addr[31:6]))
        else abort_run($sformatf("CHECK FAILED t=%0t mem_rd_addr exp=%h got=%h",
                                 $time, $sampled(exp_rd_addr), $sampled(mem_rd_addr)));
    a_fast_early: assert property (@(posedge clk) disable iff (!arst_n)
                                   $past(req_valid && exp_fast) |-> !resp_valid)
        else abort_run("response came one cycle after the request");
    a_fast_late: assert property (@(posedge clk) disable iff (!arst_n)
                                  $past(req_valid && exp_fast, 2) |-> resp_valid)
        else abort_run("response did not come two cycles after the request");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (mem_rd_req) rd_count <= rd_count + 1;
        if (line_out_valid) line_count <= line_count + 1;
    end

    // memory answers each fetch after 1 to 8 cycles
    always begin
        @(posedge clk);
        if (mem_rd_req) begin
            fetch_addr = mem_rd_addr;
            fetch_wait = mem_delay[rd_count % 64];
            for (int i = 1; i < fetch_wait; i++) begin
                @(posedge clk);
            end
            #2;
            mem_rd_line  = mem_line(fetch_addr);
            mem_rd_valid = 1'b1;
            @(posedge clk);
            #2 mem_rd_valid = 1'b0;
        end
    end

    task automatic check_count(input string name, input int expected, input int actual);
        assert (expected == actual)
            else abort_run($sformatf("CHECK FAILED t=%0t %s exp=%0d got=%0d",
                                     $time, name, expected, actual));
    endtask

    task automatic expect_set(input logic data_en, input logic [31:0] data, input logic line_en,
                              input logic [LINE_W-1:0] line, input logic fast, input logic rd);
        exp_data_en = data_en;
        exp_data    = data;
        exp_line_en = line_en;
        exp_line    = line;
        exp_fast    = fast;
        rd_ok       = rd;
    endtask

    task automatic run_access(input logic [31:0] addr, input rd_type_t typ, input logic wr,
                              input logic unc, input logic sgn, input logic sc,
                              input cacop_t cacop, input logic [31:0] wdata);
        int n;
        @(posedge clk);
        #2;
        req_valid   = 1'b1;
        req_addr    = addr;
        req_type    = typ;
        req_wr      = wr;
        req_uncache = unc;
        req_signed  = sgn;
        req_atom    = sc;
        req_sc      = sc;
        req_cacop   = cacop;
        req_wdata   = wdata;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            req_valid = 1'b0;
            n++;
            if (n > 200) abort_run("timed out waiting for resp_valid");
        end while (!resp_valid);
        @(posedge clk); // let the response edge be sampled
        #2;
    endtask

    task automatic cached_load(input logic [TAG_W-1:0] tag, input logic [IDX_W-1:0] idx,
                               input logic [3:0] wofs, input logic [1:0] bofs,
                               input rd_type_t typ, input logic sgn);
        logic [31:0] addr;
        int          way;
        int          v;
        int          rd0;
        int          ln0;
        addr = {tag, idx, wofs, bofs};
        way  = -1;
        rd0  = rd_count;
        ln0  = line_count;
        for (int w = 0; w < WAYS; w++) begin
            if (mdl_valid[idx][w] && mdl_tag[idx][w] == tag) way = w;
        end
        v = mdl_ptr[idx];
        expect_set(1'b1, expect_load(mem_word(addr), typ, sgn, bofs),
                   way < 0 && mdl_valid[idx][v], mem_line({mdl_tag[idx][v], idx, 6'b0}),
                   way >= 0, way < 0);
        exp_rd_unc  = 1'b0;
        exp_rd_addr = addr;
        if (way < 0) begin
            mdl_tag[idx][v]   = tag;
            mdl_valid[idx][v] = 1'b1;
            mdl_ptr[idx]      = (v + 1) % WAYS;
        end
        run_access(addr, typ, 1'b0, 1'b0, sgn, 1'b0, CACOP_NONE, 32'h0);
        check_count("mem_rd_req pulses", rd0 + (way < 0), rd_count);
        check_count("line_out_valid pulses", ln0 + exp_line_en, line_count);
    endtask

    initial begin
        logic [TAG_W-1:0] tags [5];
        int               rd0;
        int               ln0;
        void'($urandom(32'h91685049));
        for (int i = 0; i < 64; i++) begin
            mem_delay[i] = 1 + int'($urandom % 8);
        end
        for (int s = 0; s < SETS; s++) begin
            mdl_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                mdl_tag[s][w]   = '0;
                mdl_valid[s][w] = 1'b0;
            end
        end
        for (int i = 0; i < 5; i++) begin
            tags[i] = 20'h12345 + 20'(i * 32'h1111);
        end
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_type     = RT_WORD;
        req_wr       = 1'b0;
        req_uncache  = 1'b0;
        req_signed   = 1'b0;
        req_atom     = 1'b0;
        req_sc       = 1'b0;
        req_cacop    = CACOP_NONE;
        req_wdata    = '0;
        llbit        = 1'b0;
        mem_rd_valid = 1'b0;
        mem_rd_line  = '0;
        expect_set(1'b0, 32'h0, 1'b0, '0, 1'b0, 1'b0);
        exp_rd_unc   = 1'b0;
        exp_rd_addr  = '0;
        rd_count     = 0;
        line_count   = 0;
        cycles       = 0;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;

        cached_load(tags[0], 6'd5, 4'd3, 2'd0, RT_WORD, 1'b0); // miss
        cached_load(tags[0], 6'd5, 4'd3, 2'd0, RT_WORD, 1'b0); // now a two-cycle hit

        for (int i = 0; i < 8; i++) begin
            cached_load(tags[0], 6'd5, 4'(i), 2'(i), RT_BYTE, i[2]);
            cached_load(tags[0], 6'd5, 4'(i + 8), 2'(i), RT_HALF, i[2]);
        end

        // uncached load takes word 0 of what memory returns
        expect_set(1'b1, mem_word({20'h0abcd, 6'd9, 6'd0}), 1'b0, '0, 1'b0, 1'b1);
        exp_rd_unc  = 1'b1;
        exp_rd_addr = {20'h0abcd, 6'd9, 4'd7, 2'd0};
        rd0 = rd_count;
        run_access({20'h0abcd, 6'd9, 4'd7, 2'd0}, RT_WORD, 1'b0, 1'b1, 1'b0, 1'b0,
                   CACOP_NONE, 32'h0);
        check_count("mem_rd_req pulses", rd0 + 1, rd_count);

        expect_set(1'b0, 32'h0, 1'b1, {{(LINE_W-32){1'b0}}, {4{8'hc6}}}, 1'b1, 1'b0);
        ln0 = line_count;
        run_access({20'h0abcd, 6'd9, 4'd2, 2'd1}, RT_BYTE, 1'b1, 1'b1, 1'b0, 1'b0,
                   CACOP_NONE, 32'h123456c6);
        check_count("line_out_valid pulses", ln0 + 1, line_count);

        for (int i = 0; i < 2; i++) begin
            llbit = i[0];
            expect_set(1'b1, {31'b0, i[0]}, 1'b0, '0, 1'b1, 1'b0);
            run_access({tags[0], 6'd5, 6'd0}, RT_WORD, 1'b1, 1'b0, 1'b0, 1'b1, CACOP_NONE, 32'h0);
        end
        llbit = 1'b0;

        for (int i = 1; i < 4; i++) begin
            cached_load(tags[i], 6'd5, 4'(i), 2'd0, RT_WORD, 1'b0); // fills the remaining ways
        end

        for (int k = 0; k < WAYS; k++) begin
            expect_set(1'b0, 32'h0, 1'b1, mem_line({mdl_tag[5][k], 6'd5, 6'd0}), 1'b1, 1'b0);
            ln0 = line_count;
            run_access({20'h0, 6'd5, 4'd0, 2'(k)}, RT_WORD, 1'b0, 1'b0, 1'b0, 1'b0,
                       CACOP_IDX, 32'h0);
            check_count("line_out_valid pulses", ln0 + 1, line_count);
        end

        expect_set(1'b0, 32'h0, 1'b1, mem_line({tags[2], 6'd5, 6'd0}), 1'b1, 1'b0);
        ln0 = line_count;
        run_access({tags[2], 6'd5, 4'd5, 2'd0}, RT_WORD, 1'b0, 1'b0, 1'b0, 1'b0, CACOP_HIT, 32'h0);
        check_count("line_out_valid pulses", ln0 + 1, line_count);

        // a fifth tag pushes out the oldest line, which then misses again
        cached_load(tags[4], 6'd5, 4'd1, 2'd0, RT_WORD, 1'b0);
        cached_load(tags[0], 6'd5, 4'd3, 2'd0, RT_WORD, 1'b0);

        $display("sim passed");
        $finish;
    end

endmodule

// File: verification/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk; // period of 20

endmodule

// File: design/dcache_top.sv
module dcache_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    input  dcache_pkg::req_addr_t         req_addr,
    input  dcache_pkg::rd_type_t          req_type,
    input  logic                          req_wr,
    input  logic                          req_uncache,
    input  logic                          req_signed,
    input  logic                          req_atom,
    input  logic                          req_sc,
    input  dcache_pkg::cacop_t            req_cacop,
    input  logic [31:0]                   req_wdata,
    input  logic                          llbit,
    output logic                          resp_valid,
    output logic [31:0]                   resp_data,
    output logic                          busy,
    output logic [dcache_pkg::LINE_W-1:0] line_out,
    output logic                          line_out_valid,
    output logic                          mem_rd_req,
    output logic [31:0]                   mem_rd_addr,
    output logic                          mem_rd_uncache,
    input  logic                          mem_rd_valid,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rd_line
);
    import dcache_pkg::*;

    logic                   lk_req, lk_gnt, rf_req, rf_gnt, rf_we;
    logic [IDX_W-1:0]       lk_index, rf_index, ram_index;
    logic [TAG_W-1:0]       cmp_tag, rf_tag, ram_tag;
    logic                   ram_en, ram_we;
    way_oh_t                ram_way_oh, rf_way_oh, hit_oh, valid_oh, victim_oh;
    logic [LINE_W-1:0]      rf_line, ram_line, fill_line;
    logic [WAYS*LINE_W-1:0] mem_dout;
    logic                   miss_start, miss_uncache, refill_done, evict_valid;
    req_addr_t              miss_addr, rbuf_addr;
    rd_type_t               rbuf_type;
    cacop_t                 rbuf_cacop;
    logic                   rbuf_signed, rbuf_uncache, rbuf_atom, rbuf_sc;
    logic [31:0]            rbuf_wdata;
    logic                   r_data_sel, lk_line_valid;

    dcache_lookup u_lookup (.*, .line_out_valid(lk_line_valid));

    dcache_refill u_refill (.*);

    dcache_ram_arbiter u_arbiter (.*);

    dcache_data_ram u_data_ram (.*);

    dcache_tag_ram u_tag_ram (.*);

    dcache_rd_path u_rd_path (.*, .r_data(resp_data), .miss_sel_data(line_out));

    // maintenance and uncached store lines share the output with evictions
    assign line_out_valid = lk_line_valid || evict_valid;

endmodule

// File: design/dcache_refill.sv
module dcache_refill (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          miss_start,
    input  dcache_pkg::req_addr_t         miss_addr,
    input  logic                          miss_uncache,
    input  logic                          rf_gnt,
    input  dcache_pkg::way_oh_t           valid_oh,
    output logic                          mem_rd_req,
    output logic [31:0]                   mem_rd_addr,
    output logic                          mem_rd_uncache,
    input  logic                          mem_rd_valid,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rd_line,
    output logic                          rf_req,
    output logic                          rf_we,
    output logic [dcache_pkg::IDX_W-1:0]  rf_index,
    output dcache_pkg::way_oh_t           rf_way_oh,
    output logic [dcache_pkg::TAG_W-1:0]  rf_tag,
    output logic [dcache_pkg::LINE_W-1:0] rf_line,
    output logic [dcache_pkg::LINE_W-1:0] fill_line,
    output dcache_pkg::way_oh_t           victim_oh,
    output logic                          evict_valid,
    output logic                          refill_done
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {R_IDLE, R_VREAD, R_VCHECK, R_WAIT, R_WRITE} rf_state_t;

    rf_state_t        state;
    req_addr_t        addr_q;
    logic             unc_q;
    logic             line_ok;
    logic [WAY_W-1:0] rr_ptr [SETS];

    always_ff @(posedge clk) begin
        if (miss_start) begin
            addr_q <= miss_addr;
            unc_q  <= miss_uncache;
        end
        if (mem_rd_valid) fill_line <= mem_rd_line;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= R_IDLE;
            mem_rd_req  <= 1'b0;
            refill_done <= 1'b0;
            line_ok     <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else begin
            mem_rd_req  <= miss_start; // fetch goes out while the victim set is read
            refill_done <= 1'b0;
            if (mem_rd_valid) line_ok <= 1'b1;
            case (state)
                R_IDLE: begin
                    if (miss_start) begin
                        line_ok <= 1'b0;
                        state   <= miss_uncache ? R_WAIT : R_VREAD;
                    end
                end
                R_VREAD:  if (rf_gnt) state <= R_VCHECK;
                R_VCHECK: state <= R_WAIT;
                R_WAIT: begin
                    if (unc_q && mem_rd_valid) begin
                        refill_done <= 1'b1;
                        state       <= R_IDLE;
                    end else if (!unc_q && line_ok) begin
                        state <= R_WRITE;
                    end
                end
                R_WRITE: begin
                    if (rf_gnt) begin
                        refill_done                   <= 1'b1;
                        rr_ptr[addr_q.fields.index] <= rr_ptr[addr_q.fields.index] + 1'b1;
                        state                         <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    assign victim_oh   = way_oh_t'(1) << rr_ptr[addr_q.fields.index];
    assign evict_valid = (state == R_VCHECK) && |(valid_oh & victim_oh);

    // cached fetches ask for the whole line
    assign mem_rd_addr    = unc_q ? addr_q : {addr_q[31:6], 6'b0};
    assign mem_rd_uncache = unc_q;

    assign rf_req    = (state == R_VREAD) || (state == R_WRITE);
    assign rf_we     = state == R_WRITE;
    assign rf_index  = addr_q.fields.index;
    assign rf_way_oh = victim_oh;
    assign rf_tag    = addr_q.fields.tag;
    assign rf_line   = fill_line;

endmodule

// File: design/dcache_rd_path.sv
module dcache_rd_path (
    input  dcache_pkg::req_addr_t                         rbuf_addr,
    input  logic [31:0]                                   rbuf_wdata,
    input  dcache_pkg::way_oh_t                           hit_oh,
    input  logic [dcache_pkg::WAYS*dcache_pkg::LINE_W-1:0] mem_dout,
    input  logic [dcache_pkg::LINE_W-1:0]                 fill_line,
    input  logic                                          r_data_sel,
    input  dcache_pkg::rd_type_t                          rbuf_type,
    input  logic                                          rbuf_uncache,
    input  logic                                          rbuf_signed,
    input  dcache_pkg::way_oh_t                           victim_oh,
    input  dcache_pkg::cacop_t                            rbuf_cacop,
    input  logic                                          llbit,
    input  logic                                          rbuf_atom,
    input  logic                                          rbuf_sc,
    output logic [31:0]                                   r_data,
    output logic [dcache_pkg::LINE_W-1:0]                 miss_sel_data
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] way_data;
    logic [LINE_W-1:0] victim_data;
    logic [31:0]       word_ram;
    logic [31:0]       word_fill;
    logic [31:0]       word_sel;
    logic [7:0]        byte_val;
    logic [15:0]       half_val;
    logic [1:0]        byte_ofs;

    function automatic logic [LINE_W-1:0] pick_way(
        input logic [WAYS*LINE_W-1:0] lines,
        input way_oh_t                oh
    );
        logic [LINE_W-1:0] sel;
        sel = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (oh[w]) sel = lines[w*LINE_W +: LINE_W];
        end
        return sel;
    endfunction

    assign way_data    = pick_way(mem_dout, hit_oh);
    assign victim_data = pick_way(mem_dout, victim_oh);

    assign word_ram  = way_data[{rbuf_addr.fields.word_ofs, 5'b0} +: 32];
    assign word_fill = rbuf_uncache ? fill_line[31:0]   // uncached word always arrives in word 0
                                    : fill_line[{rbuf_addr.fields.word_ofs, 5'b0} +: 32];
    assign word_sel  = r_data_sel ? word_ram : word_fill;

    assign byte_ofs = rbuf_addr.fields.byte_ofs;
    assign byte_val = word_sel[{byte_ofs, 3'b0} +: 8];
    assign half_val = word_sel[{byte_ofs[1], 4'b0} +: 16];

    always_comb begin
        if (rbuf_atom && rbuf_sc) begin
            r_data = {31'b0, llbit};
        end else begin
            case (rbuf_type)
                RT_BYTE: r_data = {{24{byte_val[7] & rbuf_signed}}, byte_val};
                RT_HALF: r_data = byte_ofs[0] ? 32'b0 : {{16{half_val[15] & rbuf_signed}}, half_val};
                RT_WORD: r_data = word_sel;
                default: r_data = '0;
            endcase
        end
    end

    always_comb begin
        if (rbuf_cacop == CACOP_IDX) begin
            miss_sel_data = mem_dout[{rbuf_addr.idx_way.way, 9'b0} +: LINE_W];
        end else if (rbuf_cacop == CACOP_HIT) begin
            miss_sel_data = way_data;
        end else if (rbuf_uncache) begin
            case (rbuf_type)
                RT_BYTE: miss_sel_data = {{(LINE_W-32){1'b0}}, {4{rbuf_wdata[7:0]}}};
                RT_HALF: miss_sel_data = {{(LINE_W-32){1'b0}}, {2{rbuf_wdata[15:0]}}};
                RT_WORD: miss_sel_data = {{(LINE_W-32){1'b0}}, rbuf_wdata};
                default: miss_sel_data = '0;
            endcase
        end else begin
            miss_sel_data = victim_data; // line being evicted during a refill
        end
    end

endmodule

// File: design/dcache_lookup.sv
module dcache_lookup (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         req_valid,
    input  dcache_pkg::req_addr_t        req_addr,
    input  dcache_pkg::rd_type_t         req_type,
    input  logic                         req_wr,
    input  logic                         req_uncache,
    input  logic                         req_signed,
    input  logic                         req_atom,
    input  logic                         req_sc,
    input  dcache_pkg::cacop_t           req_cacop,
    input  logic [31:0]                  req_wdata,
    input  dcache_pkg::way_oh_t          hit_oh,
    input  logic                         lk_gnt,
    output logic                         lk_req,
    output logic [dcache_pkg::IDX_W-1:0] lk_index,
    output logic [dcache_pkg::TAG_W-1:0] cmp_tag,
    input  logic                         refill_done,
    output logic                         miss_start,
    output dcache_pkg::req_addr_t        miss_addr,
    output logic                         miss_uncache,
    output dcache_pkg::req_addr_t        rbuf_addr,
    output dcache_pkg::rd_type_t         rbuf_type,
    output logic                         rbuf_signed,
    output logic                         rbuf_uncache,
    output dcache_pkg::cacop_t           rbuf_cacop,
    output logic                         rbuf_atom,
    output logic                         rbuf_sc,
    output logic [31:0]                  rbuf_wdata,
    output logic                         r_data_sel,
    output logic                         resp_valid,
    output logic                         line_out_valid,
    output logic                         busy
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {IDLE, READ, CHECK, MISS_WAIT, RESPOND} state_t;

    state_t state, state_nxt;
    logic   rbuf_wr;
    logic   sc_op;
    logic   cacop_op;
    logic   ram_op;
    logic   unc_load;
    logic   hit;

    // request buffer, loaded only while idle
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            rbuf_addr    <= req_addr;
            rbuf_type    <= req_type;
            rbuf_wr      <= req_wr;
            rbuf_uncache <= req_uncache;
            rbuf_signed  <= req_signed;
            rbuf_atom    <= req_atom;
            rbuf_sc      <= req_sc;
            rbuf_cacop   <= req_cacop;
            rbuf_wdata   <= req_wdata;
        end
    end

    assign sc_op    = rbuf_atom && rbuf_sc;
    assign cacop_op = rbuf_cacop != CACOP_NONE;
    assign ram_op   = !sc_op && (cacop_op || (!rbuf_uncache && !rbuf_wr));
    assign unc_load = !sc_op && !cacop_op && rbuf_uncache && !rbuf_wr;
    assign hit      = |hit_oh;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (req_valid) state_nxt = READ;
            READ: begin
                if (ram_op) begin
                    if (lk_gnt) state_nxt = CHECK;
                end else if (unc_load) begin
                    state_nxt = MISS_WAIT;
                end else begin
                    state_nxt = RESPOND; // sc and uncached stores need no array access
                end
            end
            CHECK:     state_nxt = (cacop_op || hit) ? IDLE : MISS_WAIT;
            MISS_WAIT: if (refill_done) state_nxt = rbuf_uncache ? IDLE : READ;
            RESPOND:   state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign lk_req   = (state == READ) && ram_op;
    assign lk_index = rbuf_addr.fields.index;
    assign cmp_tag  = rbuf_addr.fields.tag;

    assign miss_start   = ((state == READ) && unc_load) ||
                          ((state == CHECK) && !cacop_op && !hit);
    assign miss_addr    = rbuf_addr;
    assign miss_uncache = rbuf_uncache;

    assign r_data_sel = state == CHECK; // array word, else the fetched line
    assign resp_valid = (state == RESPOND) ||
                        ((state == CHECK) && (cacop_op || hit)) ||
                        ((state == MISS_WAIT) && refill_done && rbuf_uncache);
    assign line_out_valid = ((state == RESPOND) && rbuf_uncache && rbuf_wr && !sc_op) ||
                            ((state == CHECK) && cacop_op);
    assign busy = state != IDLE;

endmodule

// File: design/dcache_ram_arbiter.sv
module dcache_ram_arbiter (
    input  logic                          lk_req,
    input  logic [dcache_pkg::IDX_W-1:0]  lk_index,
    input  logic                          rf_req,
    input  logic                          rf_we,
    input  logic [dcache_pkg::IDX_W-1:0]  rf_index,
    input  dcache_pkg::way_oh_t           rf_way_oh,
    input  logic [dcache_pkg::TAG_W-1:0]  rf_tag,
    input  logic [dcache_pkg::LINE_W-1:0] rf_line,
    output logic                          lk_gnt,
    output logic                          rf_gnt,
    output logic                          ram_en,
    output logic                          ram_we,
    output logic [dcache_pkg::IDX_W-1:0]  ram_index,
    output dcache_pkg::way_oh_t           ram_way_oh,
    output logic [dcache_pkg::TAG_W-1:0]  ram_tag,
    output logic [dcache_pkg::LINE_W-1:0] ram_line
);

    // refill always wins, lookup waits a cycle
    assign rf_gnt = rf_req;
    assign lk_gnt = lk_req && !rf_req;

    assign ram_en     = rf_req || lk_req;
    assign ram_we     = rf_req && rf_we;
    assign ram_index  = rf_req ? rf_index : lk_index;
    assign ram_way_oh = rf_req ? rf_way_oh : '0;
    assign ram_tag    = rf_tag;
    assign ram_line   = rf_line;

endmodule

// File: design/dcache_tag_ram.sv
module dcache_tag_ram (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         ram_en,
    input  logic                         ram_we,
    input  logic [dcache_pkg::IDX_W-1:0] ram_index,
    input  dcache_pkg::way_oh_t          ram_way_oh,
    input  logic [dcache_pkg::TAG_W-1:0] ram_tag,
    input  logic [dcache_pkg::TAG_W-1:0] cmp_tag,
    output dcache_pkg::way_oh_t          hit_oh,
    output dcache_pkg::way_oh_t          valid_oh
);
    import dcache_pkg::*;

    way_oh_t          valid_q [SETS];
    logic [TAG_W-1:0] rd_tag  [WAYS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
            valid_oh <= '0;
        end else if (ram_en) begin
            if (ram_we) begin
                valid_q[ram_index] <= valid_q[ram_index] | ram_way_oh;
            end
            valid_oh <= valid_q[ram_index];
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_W-1:0] tags [SETS];

        always_ff @(posedge clk) begin
            if (ram_en) begin
                if (ram_we && ram_way_oh[w]) begin
                    tags[ram_index] <= ram_tag;
                end
                rd_tag[w] <= tags[ram_index];
            end
        end

        // compare against the held request, so it lines up with the registered read
        assign hit_oh[w] = valid_oh[w] && (rd_tag[w] == cmp_tag);
    end

endmodule

// File: design/dcache_data_ram.sv
module dcache_data_ram (
    input  logic                                          clk,
    input  logic                                          ram_en,
    input  logic                                          ram_we,
    input  logic [dcache_pkg::IDX_W-1:0]                  ram_index,
    input  dcache_pkg::way_oh_t                           ram_way_oh,
    input  logic [dcache_pkg::LINE_W-1:0]                 ram_line,
    output logic [dcache_pkg::WAYS*dcache_pkg::LINE_W-1:0] mem_dout
);
    import dcache_pkg::*;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [LINE_W-1:0] lines [SETS];

        always_ff @(posedge clk) begin
            if (ram_en) begin
                if (ram_we && ram_way_oh[w]) begin
                    lines[ram_index] <= ram_line;
                end
                mem_dout[w*LINE_W +: LINE_W] <= lines[ram_index]; // old data on a write cycle
            end
        end
    end

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    localparam int WAYS       = 4;
    localparam int LINE_W     = 512;
    localparam int SETS       = 64;
    localparam int WAY_W      = 2;
    localparam int IDX_W      = 6;
    localparam int TAG_W      = 20;
    localparam int WORD_OFS_W = 4;

    // byte mask of the access, also used as the access size code
    typedef logic [3:0] rd_type_t;
    localparam rd_type_t RT_BYTE = 4'b0001;
    localparam rd_type_t RT_HALF = 4'b0011;
    localparam rd_type_t RT_WORD = 4'b1111;

    typedef logic [1:0] cacop_t;
    localparam cacop_t CACOP_NONE = 2'b00;
    localparam cacop_t CACOP_IDX  = 2'b01;
    localparam cacop_t CACOP_HIT  = 2'b10;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [IDX_W-1:0]      index;
        logic [WORD_OFS_W-1:0] word_ofs;
        logic [1:0]            byte_ofs;
    } addr_fields_t;

    // index-type maintenance carries the way number where the byte offset sits
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [IDX_W-1:0]      index;
        logic [WORD_OFS_W-1:0] word_ofs;
        logic [WAY_W-1:0]      way;
    } addr_idx_way_t;

    typedef union packed {
        addr_fields_t  fields;
        addr_idx_way_t idx_way;
    } req_addr_t;

    typedef logic [WAYS-1:0] way_oh_t;

endpackage
